/* verilog/sbr_sample_pkg.sv */
package sbr_sample_pkg;

  localparam int SAMPLE_W = 12;
  localparam int SEQ_W    = 8;
  localparam int DECIM_W  = 4;

  // sample FIFO, wr_clk to rd_clk.
  localparam int SAMPLE_DEPTH = 16;
  localparam int SAMPLE_AFULL = 12;

  // config FIFO, rd_clk to wr_clk.
  localparam int CFG_DEPTH = 4;
  localparam int CFG_AFULL = 3;

  // level counts run from zero up to the full depth.
  localparam int SAMPLE_LVL_W = $clog2(SAMPLE_DEPTH) + 1;
  localparam int CFG_LVL_W    = $clog2(CFG_DEPTH) + 1;

  // one kept ADC sample as it crosses to the bus side.
  typedef struct packed {
    logic                gap;   // samples were lost right before this one.
    logic [SEQ_W-1:0]    seq;
    logic [SAMPLE_W-1:0] data;
  } sample_t;

  typedef struct packed {
    logic               enable;
    logic [DECIM_W-1:0] decim;  // keep one in every decim+1.
  } cfg_t;

endpackage

/* verilog/sbr_axil_pkg.sv */
package sbr_axil_pkg;

  localparam int AXIL_AW = 4;
  localparam int AXIL_DW = 32;

  localparam logic [AXIL_AW-1:0] REG_DATA   = 'h0;
  localparam logic [AXIL_AW-1:0] REG_STATUS = 'h4;
  localparam logic [AXIL_AW-1:0] REG_CONFIG = 'h8;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // field positions inside the DATA and STATUS words.
  localparam int DATA_VALID_BIT  = 31;
  localparam int DATA_GAP_BIT    = 24;
  localparam int DATA_SEQ_LSB    = 16;
  localparam int STAT_EMPTY_BIT  = 0;
  localparam int STAT_AEMPTY_BIT = 1;
  localparam int STAT_PEND_BIT   = 2;
  localparam int STAT_LEVEL_LSB  = 8;

  typedef struct packed {
    logic                   awvalid;
    logic [AXIL_AW-1:0]     awaddr;
    logic                   wvalid;
    logic [AXIL_DW-1:0]     wdata;
    logic [AXIL_DW/8-1:0]   wstrb;
    logic                   bready;
    logic                   arvalid;
    logic [AXIL_AW-1:0]     araddr;
    logic                   rready;
  } axil_req_t;

  typedef struct packed {
    logic                   awready;
    logic                   wready;
    logic                   bvalid;
    logic [1:0]             bresp;
    logic                   arready;
    logic                   rvalid;
    logic [AXIL_DW-1:0]     rdata;
    logic [1:0]             rresp;
  } axil_rsp_t;

endpackage

/* verilog/sbr_async_fifo.sv */
module sbr_async_fifo #(
  parameter type payload_t   = logic [7:0],
  parameter int  DEPTH       = 16,
  parameter int  AFULL_LEVEL = DEPTH - 4
) (
  input  logic                   wr_clk,
  input  logic                   wr_rst_n,
  input  logic                   push,
  input  payload_t               wr_data,
  output logic                   full,
  output logic                   afull,
  output logic [$clog2(DEPTH):0] wr_level,
  input  logic                   rd_clk,
  input  logic                   pop,
  output payload_t               rd_data,
  output logic                   empty,
  output logic                   aempty,
  output logic [$clog2(DEPTH):0] rd_level
);

  localparam int AW = $clog2(DEPTH);

  typedef logic [AW:0] ptr_t;  // extra msb tells full from empty.

  payload_t mem [DEPTH];

  ptr_t wr_bin;
  ptr_t wr_bin_nxt;
  ptr_t wr_gray;
  ptr_t wr_gray_nxt;
  ptr_t rd_bin;
  ptr_t rd_bin_nxt;
  ptr_t rd_gray;
  ptr_t rd_gray_nxt;
  ptr_t wr_gray_rs1;
  ptr_t wr_gray_rs2;
  ptr_t rd_gray_ws1;
  ptr_t rd_gray_ws2;
  ptr_t wr_level_nxt;
  ptr_t rd_level_nxt;
  logic wr_en;
  logic rd_en;

  function automatic ptr_t bin2gray(input ptr_t b);
    return b ^ (b >> 1);
  endfunction

  function automatic ptr_t gray2bin(input ptr_t g);
    ptr_t b;
    b[AW] = g[AW];
    for (int i = AW - 1; i >= 0; i--) begin
      b[i] = b[i + 1] ^ g[i];
    end
    return b;
  endfunction

  assign wr_en        = push && !full;
  assign wr_bin_nxt   = wr_bin + ptr_t'(wr_en);
  assign wr_gray_nxt  = bin2gray(wr_bin_nxt);
  assign wr_level_nxt = wr_bin_nxt - gray2bin(rd_gray_ws2);  // stale read side, never low.

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_bin[AW-1:0]] <= wr_data;
    end
  end

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin      <= '0;
      wr_gray     <= '0;
      rd_gray_ws1 <= '0;
      rd_gray_ws2 <= '0;
      full        <= 1'b0;
      afull       <= 1'b0;
      wr_level    <= '0;
    end else begin
      wr_bin      <= wr_bin_nxt;
      wr_gray     <= wr_gray_nxt;
      rd_gray_ws1 <= rd_gray;
      rd_gray_ws2 <= rd_gray_ws1;
      full        <= wr_level_nxt == ptr_t'(DEPTH);
      afull       <= wr_level_nxt >= ptr_t'(AFULL_LEVEL);
      wr_level    <= wr_level_nxt;
    end
  end

  assign rd_en        = pop && !empty;
  assign rd_bin_nxt   = rd_bin + ptr_t'(rd_en);
  assign rd_gray_nxt  = bin2gray(rd_bin_nxt);
  assign rd_level_nxt = gray2bin(wr_gray_rs2) - rd_bin_nxt;

  // first word falls through.
  assign rd_data = mem[rd_bin[AW-1:0]];

  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_bin      <= '0;
      rd_gray     <= '0;
      wr_gray_rs1 <= '0;
      wr_gray_rs2 <= '0;
      empty       <= 1'b1;
      aempty      <= 1'b1;
      rd_level    <= '0;
    end else begin
      rd_bin      <= rd_bin_nxt;
      rd_gray     <= rd_gray_nxt;
      wr_gray_rs1 <= wr_gray;
      wr_gray_rs2 <= wr_gray_rs1;
      empty       <= rd_level_nxt == '0;
      aempty      <= rd_level_nxt <= ptr_t'(1);  // one entry or less.
      rd_level    <= rd_level_nxt;
    end
  end

  a_push_full: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    !(push && full));

  a_pop_empty: assert property (@(posedge rd_clk) disable iff (!wr_rst_n)
    !(pop && empty));

  // each synchronizer must see a single moving bit.
  a_wr_gray: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    $countones(wr_gray ^ $past(wr_gray)) <= 1);

  a_rd_gray: assert property (@(posedge rd_clk) disable iff (!wr_rst_n)
    $countones(rd_gray ^ $past(rd_gray)) <= 1);

endmodule

/* verilog/sbr_capture.sv */
module sbr_capture (
  input  logic                                wr_clk,
  input  logic                                wr_rst_n,
  input  logic                                sample_valid,
  input  logic [sbr_sample_pkg::SAMPLE_W-1:0] sample_data,
  input  logic                                cfg_empty,
  input  sbr_sample_pkg::cfg_t                cfg_head,
  output logic                                cfg_pop,
  input  logic                                full,
  output logic                                push,
  output sbr_sample_pkg::sample_t             sample
);

  import sbr_sample_pkg::*;

  cfg_t               cfg_q;
  logic [DECIM_W-1:0] phase;
  logic [SEQ_W-1:0]   seq_q;
  logic               gap_q;
  logic               keep;

  assign cfg_pop = !cfg_empty;  // take each head as soon as it shows.

  assign keep   = sample_valid && cfg_q.enable && (phase == '0);
  assign push   = keep && !full;
  assign sample = '{gap: gap_q, seq: seq_q, data: sample_data};

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      cfg_q <= '0;
      phase <= '0;
    end else if (!cfg_empty) begin
      cfg_q <= cfg_head;
      phase <= '0;  // new config restarts decimation.
    end else if (sample_valid && cfg_q.enable) begin
      if (phase == cfg_q.decim) begin
        phase <= '0;
      end else begin
        phase <= phase + 1'b1;
      end
    end
  end

  // seq advances on every kept sample, stored or not.
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      seq_q <= '0;
      gap_q <= 1'b0;
    end else if (keep) begin
      seq_q <= seq_q + 1'b1;
      gap_q <= full;  // held until a sample gets through.
    end
  end

endmodule

/* verilog/sbr_axil_regs.sv */
module sbr_axil_regs (
  input  logic                                    rd_clk,
  input  logic                                    wr_rst_n,
  input  sbr_axil_pkg::axil_req_t                 axil_req,
  output sbr_axil_pkg::axil_rsp_t                 axil_rsp,
  input  sbr_sample_pkg::sample_t                 sample_head,
  input  logic                                    sample_empty,
  input  logic                                    sample_aempty,
  input  logic [sbr_sample_pkg::SAMPLE_LVL_W-1:0] sample_level,
  output logic                                    sample_pop,
  input  logic                                    cfg_full,
  input  logic [sbr_sample_pkg::CFG_LVL_W-1:0]    cfg_level,
  output logic                                    cfg_push,
  output sbr_sample_pkg::cfg_t                    cfg
);

  import sbr_sample_pkg::*;
  import sbr_axil_pkg::*;

  logic               wr_hs;
  logic               rd_hs;
  logic               cfg_sel;
  logic               bvalid_q;
  logic [1:0]         bresp_q;
  logic               rvalid_q;
  logic [AXIL_DW-1:0] rdata_q;
  logic [1:0]         rresp_q;
  logic [AXIL_DW-1:0] rd_word;
  logic               rd_err;
  cfg_t               cfg_q;

  // a write is taken only with both address and data present.
  assign wr_hs   = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
  assign rd_hs   = axil_req.arvalid && !rvalid_q;
  assign cfg_sel = axil_req.awaddr == REG_CONFIG;

  assign cfg_push = wr_hs && cfg_sel && !cfg_full;
  assign cfg      = axil_req.wstrb[0] ? cfg_t'(axil_req.wdata[$bits(cfg_t)-1:0]) : cfg_q;

  assign sample_pop = rd_hs && (axil_req.araddr == REG_DATA) && !sample_empty;

  always_comb begin
    rd_word = '0;
    rd_err  = 1'b0;
    case (axil_req.araddr)
      REG_DATA: begin
        if (!sample_empty) begin
          rd_word[DATA_VALID_BIT]            = 1'b1;
          rd_word[DATA_GAP_BIT]              = sample_head.gap;
          rd_word[DATA_SEQ_LSB +: SEQ_W]     = sample_head.seq;
          rd_word[SAMPLE_W-1:0]              = sample_head.data;
        end
      end
      REG_STATUS: begin
        rd_word[STAT_EMPTY_BIT]                 = sample_empty;
        rd_word[STAT_AEMPTY_BIT]                = sample_aempty;
        rd_word[STAT_PEND_BIT]                  = cfg_level != '0;  // not yet in capture.
        rd_word[STAT_LEVEL_LSB +: SAMPLE_LVL_W] = sample_level;
      end
      REG_CONFIG: begin
        rd_word[$bits(cfg_t)-1:0] = cfg_q;
      end
      default: begin
        rd_err = 1'b1;
      end
    endcase
  end

  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
      cfg_q    <= '0;
    end else begin
      if (wr_hs) begin
        bvalid_q <= 1'b1;
      end else if (axil_req.bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_hs) begin
        rvalid_q <= 1'b1;
      end else if (axil_req.rready) begin
        rvalid_q <= 1'b0;
      end
      if (cfg_push) begin
        cfg_q <= cfg;  // readback copy.
      end
    end
  end

  always_ff @(posedge rd_clk) begin
    if (wr_hs) begin
      bresp_q <= cfg_push ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_hs) begin
      rdata_q <= rd_word;
      rresp_q <= rd_err ? RESP_SLVERR : RESP_OKAY;
    end
  end

  assign axil_rsp = '{awready: wr_hs,
                      wready:  wr_hs,
                      bvalid:  bvalid_q,
                      bresp:   bresp_q,
                      arready: !rvalid_q,
                      rvalid:  rvalid_q,
                      rdata:   rdata_q,
                      rresp:   rresp_q};

  a_b_hold: assert property (@(posedge rd_clk) disable iff (!wr_rst_n)
    axil_rsp.bvalid && !axil_req.bready
      |=> axil_rsp.bvalid && $stable(axil_rsp.bresp));

  a_r_hold: assert property (@(posedge rd_clk) disable iff (!wr_rst_n)
    axil_rsp.rvalid && !axil_req.rready
      |=> axil_rsp.rvalid && $stable(axil_rsp.rdata) && $stable(axil_rsp.rresp));

endmodule

/* verilog/sbr_top.sv */
module sbr_top (
  input  logic                                rd_clk,
  input  logic                                wr_clk,
  input  logic                                wr_rst_n,
  input  logic                                sample_valid,
  input  logic [sbr_sample_pkg::SAMPLE_W-1:0] sample_data,
  input  sbr_axil_pkg::axil_req_t             axil_req,
  output sbr_axil_pkg::axil_rsp_t             axil_rsp
);

  import sbr_sample_pkg::*;

  sample_t                 cap_sample;
  logic                    cap_push;
  logic                    smp_full;
  sample_t                 smp_head;
  logic                    smp_empty;
  logic                    smp_aempty;
  logic [SAMPLE_LVL_W-1:0] smp_level;
  logic                    smp_pop;
  cfg_t                    reg_cfg;
  logic                    reg_cfg_push;
  logic                    cfg_full;
  logic [CFG_LVL_W-1:0]    cfg_level;
  cfg_t                    cfg_head;
  logic                    cfg_empty;
  logic                    cfg_pop;

  sbr_capture capture_i (
    .wr_clk       (wr_clk),
    .wr_rst_n     (wr_rst_n),
    .sample_valid (sample_valid),
    .sample_data  (sample_data),
    .cfg_empty    (cfg_empty),
    .cfg_head     (cfg_head),
    .cfg_pop      (cfg_pop),
    .full         (smp_full),
    .push         (cap_push),
    .sample       (cap_sample)
  );

  sbr_async_fifo #(
    .payload_t   (sample_t),
    .DEPTH       (SAMPLE_DEPTH),
    .AFULL_LEVEL (SAMPLE_AFULL)
  ) sample_fifo_i (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .push     (cap_push),
    .wr_data  (cap_sample),
    .full     (smp_full),
    .afull    (),
    .wr_level (),
    .rd_clk   (rd_clk),
    .pop      (smp_pop),
    .rd_data  (smp_head),
    .empty    (smp_empty),
    .aempty   (smp_aempty),
    .rd_level (smp_level)
  );

  // config travels the other way, bus side to capture.
  sbr_async_fifo #(
    .payload_t   (cfg_t),
    .DEPTH       (CFG_DEPTH),
    .AFULL_LEVEL (CFG_AFULL)
  ) cfg_fifo_i (
    .wr_clk   (rd_clk),
    .wr_rst_n (wr_rst_n),
    .push     (reg_cfg_push),
    .wr_data  (reg_cfg),
    .full     (cfg_full),
    .afull    (),
    .wr_level (cfg_level),
    .rd_clk   (wr_clk),
    .pop      (cfg_pop),
    .rd_data  (cfg_head),
    .empty    (cfg_empty),
    .aempty   (),
    .rd_level ()
  );

  sbr_axil_regs regs_i (
    .rd_clk        (rd_clk),
    .wr_rst_n      (wr_rst_n),
    .axil_req      (axil_req),
    .axil_rsp      (axil_rsp),
    .sample_head   (smp_head),
    .sample_empty  (smp_empty),
    .sample_aempty (smp_aempty),
    .sample_level  (smp_level),
    .sample_pop    (smp_pop),
    .cfg_full      (cfg_full),
    .cfg_level     (cfg_level),
    .cfg_push      (reg_cfg_push),
    .cfg           (reg_cfg)
  );

endmodule

/* testbench/sbr_tb.sv */
module sbr_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import sbr_sample_pkg::*;
  import sbr_axil_pkg::*;

  localparam int          BUS_TIMEOUT = 20;  // rd_clk cycles for one response.
  localparam int          POLL_LIMIT  = 40;  // register reads before giving up.
  localparam logic [15:0] LFSR_SEED   = 16'd46;

  typedef enum logic [2:0] {
    OP_WRITE, OP_READ, OP_READ_ERR, OP_POLL, OP_SEND, OP_DRAIN, OP_IDLE
  } op_e;

  // exp holds a response code, a read word or a count depending on op.
  typedef struct packed {
    op_e                op;
    logic [AXIL_AW-1:0] addr;
    logic [AXIL_DW-1:0] wdata;
    logic [AXIL_DW-1:0] exp;
  } step_t;

  logic                rd_clk;
  logic                wr_clk;
  logic                wr_rst_n;
  logic                sample_valid;
  logic [SAMPLE_W-1:0] sample_data;
  axil_req_t           req;
  axil_rsp_t           rsp;

  logic [15:0]         lfsr_state;
  step_t               steps[$];
  string               step_names[$];
  cfg_t                model_cfg;
  int                  model_index;
  logic [SEQ_W-1:0]    model_seq;
  logic                model_gap;
  sample_t             model_q[$];

  sbr_top dut_i (
    .rd_clk       (rd_clk),
    .wr_clk       (wr_clk),
    .wr_rst_n     (wr_rst_n),
    .sample_valid (sample_valid),
    .sample_data  (sample_data),
    .axil_req     (req),
    .axil_rsp     (rsp)
  );

  initial begin
    rd_clk = 1'b0;
    forever #10 rd_clk = ~rd_clk;
  end

  initial begin
    wr_clk = 1'b0;
    forever #7 wr_clk = ~wr_clk;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  function automatic string sample_text(input sample_t s);
    return $sformatf("gap %0d seq %0d data %03h", s.gap, s.seq, s.data);
  endfunction

  task automatic check_rsp(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (exp !== act) begin
      stop_on_error($sformatf("error %s: expected resp %0d, actual resp %0d", name, exp, act));
    end
  endtask

  task automatic check_word(input string name, input logic [AXIL_DW-1:0] exp,
                            input logic [AXIL_DW-1:0] act);
    if (exp !== act) begin
      stop_on_error($sformatf("error %s: expected %08h, actual %08h", name, exp, act));
    end
  endtask

  task automatic check_sample(input string name, input sample_t exp, input sample_t act);
    if (exp !== act) begin
      stop_on_error($sformatf("error %s: expected %s, actual %s", name,
                              sample_text(exp), sample_text(act)));
    end
  endtask

  // galois form with taps 16 14 13 11.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_random_bits(output logic [SAMPLE_W-1:0] v);
    v = '0;
    for (int i = 0; i < SAMPLE_W; i++) begin
      v          = {v[SAMPLE_W-2:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // kept samples take a seq even when the FIFO has no room.
  task automatic predict_sample(input logic [SAMPLE_W-1:0] d);
    sample_t s;
    if (model_cfg.enable) begin
      if (model_index % (int'(model_cfg.decim) + 1) == 0) begin
        if (model_q.size() == SAMPLE_DEPTH) begin
          model_gap = 1'b1;
        end else begin
          s.gap  = model_gap;
          s.seq  = model_seq;
          s.data = d;
          model_q.push_back(s);
          model_gap = 1'b0;
        end
        model_seq = model_seq + SEQ_W'(1);
      end
      model_index++;
    end
  endtask

  task automatic send_samples(input int count);
    logic [SAMPLE_W-1:0] d;
    for (int i = 0; i < count; i++) begin
      take_random_bits(d);
      @(negedge wr_clk);
      sample_valid = 1'b1;
      sample_data  = d;
      predict_sample(d);
    end
    @(negedge wr_clk);
    sample_valid = 1'b0;
  endtask

  task automatic axil_write(input string name, input logic [AXIL_AW-1:0] addr,
                            input logic [AXIL_DW-1:0] data, output logic [1:0] resp);
    int waited;
    waited = 0;
    @(negedge rd_clk);
    req.awvalid = 1'b1;
    req.awaddr  = addr;
    req.wvalid  = 1'b1;
    req.wdata   = data;
    req.wstrb   = '1;
    @(posedge rd_clk);  // the handshake is taken on the rising edge.
    while (!(rsp.awready && rsp.wready) && waited < BUS_TIMEOUT) begin
      @(posedge rd_clk);
      waited++;
    end
    if (!(rsp.awready && rsp.wready)) begin
      stop_on_error($sformatf("%s: the write was not accepted in time", name));
    end
    @(negedge rd_clk);
    if (!rsp.bvalid) begin
      stop_on_error($sformatf("%s: no write response one cycle after the handshake", name));
    end
    resp        = rsp.bresp;
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    req.bready  = 1'b1;
    @(negedge rd_clk);
    req.bready  = 1'b0;
  endtask

  task automatic axil_read(input string name, input logic [AXIL_AW-1:0] addr,
                           output logic [AXIL_DW-1:0] data, output logic [1:0] resp);
    int waited;
    waited = 0;
    @(negedge rd_clk);
    req.arvalid = 1'b1;
    req.araddr  = addr;
    @(posedge rd_clk);
    while (!rsp.arready && waited < BUS_TIMEOUT) begin
      @(posedge rd_clk);
      waited++;
    end
    if (!rsp.arready) begin
      stop_on_error($sformatf("%s: the read address was not accepted in time", name));
    end
    @(negedge rd_clk);
    if (!rsp.rvalid) begin
      stop_on_error($sformatf("%s: no read data one cycle after the handshake", name));
    end
    data        = rsp.rdata;
    resp        = rsp.rresp;
    req.arvalid = 1'b0;
    req.rready  = 1'b1;
    @(negedge rd_clk);
    req.rready  = 1'b0;
  endtask

  task automatic poll_word(input string name, input logic [AXIL_AW-1:0] addr,
                           input logic [AXIL_DW-1:0] exp);
    logic [AXIL_DW-1:0] word;
    logic [1:0]         resp;
    int                 tries;
    tries = 0;
    axil_read(name, addr, word, resp);
    while (word !== exp && tries < POLL_LIMIT) begin
      axil_read(name, addr, word, resp);
      tries++;
    end
    check_rsp(name, RESP_OKAY, resp);
    check_word(name, exp, word);
  endtask

  task automatic drain_samples(input string name, input int count);
    logic [AXIL_DW-1:0] word;
    logic [1:0]         resp;
    sample_t            exp;
    sample_t            act;
    int                 tries;
    for (int k = 0; k < count; k++) begin
      tries = 0;
      word  = '0;
      while (!word[DATA_VALID_BIT] && tries < POLL_LIMIT) begin
        axil_read(name, REG_DATA, word, resp);
        tries++;
      end
      if (!word[DATA_VALID_BIT]) begin
        stop_on_error($sformatf("%s: no sample showed up in the DATA register", name));
      end
      if (model_q.size() == 0) begin
        stop_on_error($sformatf("%s: a sample came out that was not expected", name));
      end
      exp      = model_q.pop_front();
      act.gap  = word[DATA_GAP_BIT];
      act.seq  = word[DATA_SEQ_LSB +: SEQ_W];
      act.data = word[SAMPLE_W-1:0];
      check_rsp(name, RESP_OKAY, resp);
      check_sample(name, exp, act);
    end
  endtask

  task automatic add_step(input string name, input op_e op, input logic [AXIL_AW-1:0] addr,
                          input logic [AXIL_DW-1:0] wdata, input logic [AXIL_DW-1:0] exp);
    step_t s;
    s.op    = op;
    s.addr  = addr;
    s.wdata = wdata;
    s.exp   = exp;
    steps.push_back(s);
    step_names.push_back(name);
  endtask

  task automatic build_table();
    add_step("reset_status",   OP_READ,     REG_STATUS, 32'h0,  32'h3);
    add_step("reset_config",   OP_READ,     REG_CONFIG, 32'h0,  32'h0);
    add_step("reset_data",     OP_READ,     REG_DATA,   32'h0,  32'h0);
    add_step("disabled_send",  OP_SEND,     REG_DATA,   32'h0,  32'd6);
    add_step("disabled_idle",  OP_IDLE,     REG_DATA,   32'h0,  32'd10);
    add_step("disabled_data",  OP_READ,     REG_DATA,   32'h0,  32'h0);
    add_step("en_cfg",         OP_WRITE,    REG_CONFIG, 32'h10, 32'(RESP_OKAY));
    add_step("en_apply",       OP_POLL,     REG_STATUS, 32'h0,  32'h3);
    add_step("burst8_send",    OP_SEND,     REG_DATA,   32'h0,  32'd8);
    add_step("burst8_read",    OP_DRAIN,    REG_DATA,   32'h0,  32'd8);
    add_step("burst8_level",   OP_READ,     REG_STATUS, 32'h0,  32'h3);
    add_step("decim2_cfg",     OP_WRITE,    REG_CONFIG, 32'h12, 32'(RESP_OKAY));
    add_step("decim2_apply",   OP_POLL,     REG_STATUS, 32'h0,  32'h3);
    add_step("decim2_send",    OP_SEND,     REG_DATA,   32'h0,  32'd12);
    add_step("decim2_read",    OP_DRAIN,    REG_DATA,   32'h0,  32'd4);
    add_step("ovf_cfg",        OP_WRITE,    REG_CONFIG, 32'h10, 32'(RESP_OKAY));
    add_step("ovf_apply",      OP_POLL,     REG_STATUS, 32'h0,  32'h3);
    add_step("ovf_send",       OP_SEND,     REG_DATA,   32'h0,  32'd20);
    add_step("ovf_level",      OP_POLL,     REG_STATUS, 32'h0,  32'h1000);
    add_step("ovf_drain",      OP_DRAIN,    REG_DATA,   32'h0,  32'd16);
    add_step("ovf_empty",      OP_READ,     REG_STATUS, 32'h0,  32'h3);
    add_step("ovf_next_send",  OP_SEND,     REG_DATA,   32'h0,  32'd1);
    add_step("ovf_next_level", OP_POLL,     REG_STATUS, 32'h0,  32'h102);
    add_step("ovf_next_read",  OP_DRAIN,    REG_DATA,   32'h0,  32'd1);
    add_step("data_write",     OP_WRITE,    REG_DATA,   32'h1,  32'(RESP_SLVERR));
    add_step("bad_write",      OP_WRITE,    4'hC,       32'h1,  32'(RESP_SLVERR));
    add_step("bad_read",       OP_READ_ERR, 4'hC,       32'h0,  32'h0);
    add_step("cfg_write",      OP_WRITE,    REG_CONFIG, 32'h15, 32'(RESP_OKAY));
    add_step("cfg_apply",      OP_POLL,     REG_STATUS, 32'h0,  32'h3);
    add_step("cfg_readback",   OP_READ,     REG_CONFIG, 32'h0,  32'h15);
  endtask

  task automatic run_step(input string name, input step_t st);
    logic [AXIL_DW-1:0] word;
    logic [1:0]         resp;
    case (st.op)
      OP_WRITE: begin
        axil_write(name, st.addr, st.wdata, resp);
        check_rsp(name, st.exp[1:0], resp);
        if (st.addr == REG_CONFIG && st.exp[1:0] == RESP_OKAY) begin
          model_cfg   = cfg_t'(st.wdata[$bits(cfg_t)-1:0]);
          model_index = 0;  // capture restarts decimation on new config.
        end
      end
      OP_READ: begin
        axil_read(name, st.addr, word, resp);
        check_rsp(name, RESP_OKAY, resp);
        check_word(name, st.exp, word);
      end
      OP_READ_ERR: begin
        axil_read(name, st.addr, word, resp);
        check_rsp(name, RESP_SLVERR, resp);
      end
      OP_POLL:  poll_word(name, st.addr, st.exp);
      OP_SEND:  send_samples(int'(st.exp));
      OP_DRAIN: drain_samples(name, int'(st.exp));
      OP_IDLE:  repeat (int'(st.exp)) @(negedge rd_clk);
      default:  stop_on_error($sformatf("%s: the step has an unknown operation", name));
    endcase
  endtask

  initial begin
    wr_rst_n     = 1'b0;
    sample_valid = 1'b0;
    sample_data  = '0;
    req          = '0;
    lfsr_state   = LFSR_SEED;
    model_cfg    = '0;
    model_index  = 0;
    model_seq    = '0;
    model_gap    = 1'b0;
    build_table();
    repeat (4) @(posedge rd_clk);
    @(negedge rd_clk);
    wr_rst_n = 1'b1;
    for (int i = 0; i < steps.size(); i++) begin
      run_step(step_names[i], steps[i]);
    end
    if (model_q.size() != 0) begin
      stop_on_error("samples were predicted that never came out of the DUT");
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

/* compile.f */
verilog/sbr_sample_pkg.sv
verilog/sbr_axil_pkg.sv
verilog/sbr_async_fifo.sv
verilog/sbr_capture.sv
verilog/sbr_axil_regs.sv
verilog/sbr_top.sv
testbench/sbr_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the sample bridge testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  -f compile.f --top-module sbr_tb -o sbr_sim > "$build_log" 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see $build_log"
  exit 1
fi

./obj_dir/sbr_sim > "$sim_log" 2>&1
run_status=$?
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status, see $sim_log"
  exit 1
fi

if grep -qx "sim passed" "$sim_log"; then
  echo "PASS"
  exit 0
else
  echo "FAIL, see $sim_log"
  exit 1
fi
